// File: verilog/icache_bypass_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared definitions of the uncached fetch path: port count,
// address and data widths, derived alignments, vector types
// and the sequencer state encoding
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package icache_bypass_pkg;

  // Number of independent fetch ports
  localparam int unsigned NR_FETCH_PORTS = 2;

  localparam int unsigned FETCH_AW   = 32;
  localparam int unsigned FETCH_DW   = 32;
  localparam int unsigned LINE_WIDTH = 128;

  // Byte offsets within a fetch word and within a refill line
  localparam int unsigned FETCH_ALIGN = $clog2(FETCH_DW / 8);
  localparam int unsigned LINE_ALIGN  = $clog2(LINE_WIDTH / 8);

  // Index of a fetch word inside a line
  localparam int unsigned WORD_SEL_W = LINE_ALIGN - FETCH_ALIGN;

  localparam int unsigned PORT_IDX_W = (NR_FETCH_PORTS == 1) ? 1 : $clog2(NR_FETCH_PORTS);

  // Outstanding refills that the order FIFO can track
  localparam int unsigned RSP_FIFO_DEPTH = 4;
  localparam int unsigned ORDER_PTR_W    = $clog2(RSP_FIFO_DEPTH);
  localparam int unsigned ORDER_CNT_W    = $clog2(RSP_FIFO_DEPTH + 1);

  typedef logic [FETCH_AW-1:0]       fetch_addr_t;
  typedef logic [FETCH_DW-1:0]       fetch_data_t;
  typedef logic [LINE_WIDTH-1:0]     line_data_t;
  typedef logic [NR_FETCH_PORTS-1:0] port_mask_t;
  typedef logic [PORT_IDX_W-1:0]     port_idx_t;
  typedef logic [WORD_SEL_W-1:0]     word_sel_t;

  // Per-port sequencer, one pass per fetch
  typedef enum logic [1:0] {
    IDLE,
    REQUEST,
    WAIT_RSP,
    PRESENT
  } bypass_state_e;

endpackage

// File: verilog/bypass_bus_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bundle between the port sequencers, the refill
// arbiter and the response router
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

interface bypass_bus_if;
  import icache_bypass_pkg::*;

  // Request side, one entry per fetch port
  logic        [NR_FETCH_PORTS-1:0] req_valid;
  fetch_addr_t [NR_FETCH_PORTS-1:0] req_addr;
  logic        [NR_FETCH_PORTS-1:0] req_grant;

  // Response side, the line and error are broadcast and only valid is steered
  logic [NR_FETCH_PORTS-1:0] rsp_valid;
  line_data_t                rsp_line;
  logic                      rsp_error;

  // No room left to record another outstanding refill
  logic order_full;

  modport seq (
    output req_valid,
    output req_addr,
    input  req_grant,
    input  rsp_valid,
    input  rsp_line,
    input  rsp_error,
    input  order_full
  );

  modport arb (
    input  req_valid,
    input  req_addr,
    output req_grant
  );

  modport router (
    output rsp_valid,
    output rsp_line,
    output rsp_error,
    output order_full
  );

endinterface

// File: verilog/bypass_port_seq.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Per-port fetch sequencer: FSM that issues one line
// refill per fetch, picks the word out of the returned
// line and presents it for a single cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module bypass_port_seq #(
  parameter int unsigned PORT_IDX = 0
) (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  input  icache_bypass_pkg::fetch_addr_t inst_addr_i,
  input  logic                           inst_valid_i,
  output logic                           inst_ready_o,
  output icache_bypass_pkg::fetch_data_t inst_data_o,
  output logic                           inst_error_o,
  bypass_bus_if.seq                      bus
);
  import icache_bypass_pkg::*;

  bypass_state_e state_q;
  bypass_state_e state_d;

  fetch_addr_t line_addr;
  word_sel_t   word_sel;
  logic        rsp_take;

  fetch_data_t data_q;
  logic        error_q;

  // Refills always fetch a whole line, so drop the offset bits
  assign line_addr = {inst_addr_i[FETCH_AW-1:LINE_ALIGN], {LINE_ALIGN{1'b0}}};
  assign word_sel  = inst_addr_i[LINE_ALIGN-1:FETCH_ALIGN];

  // Hold back while the order FIFO cannot record one more refill
  assign bus.req_valid[PORT_IDX] = (state_q == REQUEST) && !bus.order_full;
  assign bus.req_addr[PORT_IDX]  = line_addr;

  // The router only steers a response here when this port heads the order FIFO
  assign rsp_take = (state_q == WAIT_RSP) && bus.rsp_valid[PORT_IDX];

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (inst_valid_i) begin
          state_d = REQUEST;
        end
      end
      REQUEST: begin
        // A grant is only given in the cycle the refill request is accepted
        if (bus.req_grant[PORT_IDX]) begin
          state_d = WAIT_RSP;
        end
      end
      WAIT_RSP: begin
        if (rsp_take) begin
          state_d = PRESENT;
        end
      end
      PRESENT: begin
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Word and error are captured from the response and served out of the register
  always_ff @(posedge clk_i) begin
    if (rsp_take) begin
      data_q  <= bus.rsp_line[word_sel*FETCH_DW +: FETCH_DW];
      error_q <= bus.rsp_error;
    end
  end

  assign inst_ready_o = (state_q == PRESENT);
  assign inst_data_o  = data_q;
  assign inst_error_o = error_q;

  // The word select is taken from the live address, so it must not move mid-fetch
  a_addr_stable : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (state_q != IDLE) |-> $stable(inst_addr_i)
  ) else $error("port %0d changed its fetch address while a fetch was in flight", PORT_IDX);

endmodule

// File: verilog/bypass_req_arb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Round-robin arbiter over the port requests that drives
// the refill request and reports each grant to the order FIFO
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module bypass_req_arb (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  bypass_bus_if.arb                      bus,
  output icache_bypass_pkg::fetch_addr_t refill_req_addr_o,
  output logic                           refill_req_valid_o,
  input  logic                           refill_req_ready_i,
  output icache_bypass_pkg::port_mask_t  push_mask_o
);
  import icache_bypass_pkg::*;

  port_idx_t  rr_q;
  logic       lock_q;
  port_idx_t  lock_idx_q;

  port_idx_t  cand;
  port_idx_t  pick_idx;
  logic       pick_found;
  port_idx_t  sel_idx;
  port_mask_t sel_mask;
  logic       accept;

  // Search starts at the port after the last winner
  always_comb begin
    pick_found = 1'b0;
    pick_idx   = rr_q;
    cand       = rr_q;
    for (int unsigned k = 0; k < NR_FETCH_PORTS; k++) begin
      cand = port_idx_t'((rr_q + k) % NR_FETCH_PORTS);
      if (!pick_found && bus.req_valid[cand]) begin
        pick_found = 1'b1;
        pick_idx   = cand;
      end
    end
  end

  // A request that was shown but not taken keeps its port until accepted
  assign sel_idx  = lock_q ? lock_idx_q : pick_idx;
  assign sel_mask = port_mask_t'(1) << sel_idx;

  assign refill_req_valid_o = bus.req_valid[sel_idx];
  assign refill_req_addr_o  = bus.req_addr[sel_idx];
  assign accept             = refill_req_valid_o && refill_req_ready_i;

  assign bus.req_grant = accept ? sel_mask : '0;
  assign push_mask_o   = accept ? sel_mask : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_q       <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      if (accept) begin
        lock_q <= 1'b0;
        rr_q   <= (sel_idx == port_idx_t'(NR_FETCH_PORTS - 1)) ? '0 : sel_idx + 1'b1;
      end else if (refill_req_valid_o) begin
        lock_q     <= 1'b1;
        lock_idx_q <= sel_idx;
      end
    end
  end

  // A granted port has its refill recorded, so it must not ask again for the same fetch
  a_grant_taken : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (bus.req_grant != '0) |=> ((bus.req_valid & $past(bus.req_grant)) == '0)
  ) else $error("granted port raised its request again in the next cycle");

  // Relies on the sequencers keeping their request up until granted
  a_req_held : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (refill_req_valid_o && !refill_req_ready_i) |=>
      (refill_req_valid_o && $stable(refill_req_addr_o))
  ) else $error("refill request dropped or changed before it was accepted");

endmodule

// File: verilog/bypass_rsp_router.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Order FIFO of granted port masks, steers each in-order
// refill response to the port that asked for it
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module bypass_rsp_router (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  icache_bypass_pkg::port_mask_t push_mask_i,
  bypass_bus_if.router                  bus,
  input  icache_bypass_pkg::line_data_t refill_rsp_data_i,
  input  logic                          refill_rsp_error_i,
  input  logic                          refill_rsp_valid_i,
  output logic                          refill_rsp_ready_o
);
  import icache_bypass_pkg::*;

  port_mask_t [RSP_FIFO_DEPTH-1:0] order_mem;

  logic [ORDER_PTR_W-1:0] wr_ptr_q;
  logic [ORDER_PTR_W-1:0] rd_ptr_q;
  logic [ORDER_CNT_W-1:0] count_q;

  logic       push;
  logic       pop;
  logic       empty;
  port_mask_t head_mask;
  port_idx_t  head_idx;

  assign push  = |push_mask_i;
  assign empty = (count_q == '0);
  assign pop   = refill_rsp_valid_i && refill_rsp_ready_o;

  always_ff @(posedge clk_i) begin
    if (push) begin
      order_mem[wr_ptr_q] <= push_mask_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == ORDER_PTR_W'(RSP_FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ORDER_PTR_W'(RSP_FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      unique case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Head entry is one-hot, turn it into an index for the valid steering
  assign head_mask = order_mem[rd_ptr_q];

  always_comb begin
    head_idx = '0;
    for (int unsigned p = 0; p < NR_FETCH_PORTS; p++) begin
      if (head_mask[p]) begin
        head_idx = port_idx_t'(p);
      end
    end
  end

  // Responses are only taken while some port is known to be waiting
  assign refill_rsp_ready_o = !empty;

  assign bus.rsp_valid  = (refill_rsp_valid_i && !empty) ? (port_mask_t'(1) << head_idx) : '0;
  assign bus.rsp_line   = refill_rsp_data_i;
  assign bus.rsp_error  = refill_rsp_error_i;
  assign bus.order_full = (count_q == ORDER_CNT_W'(RSP_FIFO_DEPTH));

  a_no_push_full : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    push |-> (count_q < ORDER_CNT_W'(RSP_FIFO_DEPTH))
  ) else $error("refill granted while the order FIFO was full");

  // The refill side must never answer more requests than were accepted
  a_no_rsp_empty : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    refill_rsp_valid_i |-> !empty
  ) else $error("refill response with no outstanding request");

endmodule

// File: verilog/icache_bypass_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Uncached instruction fetch path: port sequencers,
// refill arbiter and response router
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module icache_bypass_top (
  input  logic clk_i,
  input  logic arst_n_i,

  // Fetch ports
  input  icache_bypass_pkg::fetch_addr_t [icache_bypass_pkg::NR_FETCH_PORTS-1:0] inst_addr_i,
  input  logic [icache_bypass_pkg::NR_FETCH_PORTS-1:0]                          inst_valid_i,
  output logic [icache_bypass_pkg::NR_FETCH_PORTS-1:0]                          inst_ready_o,
  output icache_bypass_pkg::fetch_data_t [icache_bypass_pkg::NR_FETCH_PORTS-1:0] inst_data_o,
  output logic [icache_bypass_pkg::NR_FETCH_PORTS-1:0]                          inst_error_o,

  // Refill request, line aligned
  output icache_bypass_pkg::fetch_addr_t refill_req_addr_o,
  output logic                           refill_req_valid_o,
  input  logic                           refill_req_ready_i,

  // Refill response, returned in request order
  input  icache_bypass_pkg::line_data_t  refill_rsp_data_i,
  input  logic                           refill_rsp_error_i,
  input  logic                           refill_rsp_valid_i,
  output logic                           refill_rsp_ready_o
);
  import icache_bypass_pkg::*;

  bypass_bus_if bus0 ();

  // Ports granted in the current cycle, recorded by the router
  port_mask_t push_mask;

  for (genvar i = 0; i < NR_FETCH_PORTS; i++) begin : gen_seq
    bypass_port_seq #(
      .PORT_IDX ( i )
    ) i_port_seq (
      .clk_i        ( clk_i           ),
      .arst_n_i     ( arst_n_i        ),
      .inst_addr_i  ( inst_addr_i[i]  ),
      .inst_valid_i ( inst_valid_i[i] ),
      .inst_ready_o ( inst_ready_o[i] ),
      .inst_data_o  ( inst_data_o[i]  ),
      .inst_error_o ( inst_error_o[i] ),
      .bus          ( bus0.seq        )
    );
  end

  bypass_req_arb i_req_arb (
    .clk_i              ( clk_i              ),
    .arst_n_i           ( arst_n_i           ),
    .bus                ( bus0.arb           ),
    .refill_req_addr_o  ( refill_req_addr_o  ),
    .refill_req_valid_o ( refill_req_valid_o ),
    .refill_req_ready_i ( refill_req_ready_i ),
    .push_mask_o        ( push_mask          )
  );

  bypass_rsp_router i_rsp_router (
    .clk_i              ( clk_i              ),
    .arst_n_i           ( arst_n_i           ),
    .push_mask_i        ( push_mask          ),
    .bus                ( bus0.router        ),
    .refill_rsp_data_i  ( refill_rsp_data_i  ),
    .refill_rsp_error_i ( refill_rsp_error_i ),
    .refill_rsp_valid_i ( refill_rsp_valid_i ),
    .refill_rsp_ready_o ( refill_rsp_ready_o )
  );

endmodule

// File: verif/tb_refill_model.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Refill memory model: in-order responses after random
// delays, line reference function and the LFSR
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_refill_model #(
  parameter int unsigned MAX_STALL     = 3,
  parameter int unsigned SHORT_DELAY_W = 2,
  parameter int unsigned LONG_DELAY_W  = 5
) (
  input  logic                           clk_i,
  input  icache_bypass_pkg::fetch_addr_t req_addr_i,
  input  logic                           req_valid_i,
  output logic                           req_ready_o,
  output icache_bypass_pkg::line_data_t  rsp_data_o,
  output logic                           rsp_error_o,
  output logic                           rsp_valid_o,
  input  logic                           rsp_ready_i,
  input  logic                           stall_en_i,
  input  logic                           long_delay_i
);
  timeunit 1ns;
  timeprecision 100ps;
  import icache_bypass_pkg::*;

  logic [31:0] lfsr_q;
  fetch_addr_t pend_addr[$];
  int unsigned pend_due[$];
  int unsigned cycle;
  int unsigned stall_run;

  // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int unsigned i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  // Fixed hash of a word's byte address
  function automatic fetch_data_t word_hash(input fetch_addr_t a);
    fetch_data_t h;
    h = a ^ 32'h2c1b3c6d;
    h = h * 32'h9e3779b1;
    h = h ^ (h >> 16);
    return h;
  endfunction

  // Word 0 of the line sits in the lowest bits
  function automatic line_data_t ref_line(input fetch_addr_t line_addr);
    line_data_t l;
    l = '0;
    for (int w = LINE_WIDTH / FETCH_DW - 1; w >= 0; w--) begin
      l = {l[LINE_WIDTH-FETCH_DW-1:0], word_hash(line_addr + fetch_addr_t'(w * (FETCH_DW / 8)))};
    end
    return l;
  endfunction

  initial begin
    fetch_addr_t head;
    logic        ready_next;
    lfsr_q      = 32'h46b1;
    cycle       = 0;
    stall_run   = 0;
    ready_next  = 1'b1;
    req_ready_o = 1'b0;
    rsp_valid_o = 1'b0;
    rsp_data_o  = '0;
    rsp_error_o = 1'b0;
    forever begin
      @(negedge clk_i);
      cycle++;
      req_ready_o = ready_next;
      if (pend_addr.size() > 0 && cycle >= pend_due[0]) begin
        head        = pend_addr[0];
        rsp_valid_o = 1'b1;
        rsp_data_o  = ref_line(head);
        rsp_error_o = (head[FETCH_AW-1 -: 4] == 4'hF);
      end else begin
        rsp_valid_o = 1'b0;
        rsp_data_o  = '0;
        rsp_error_o = 1'b0;
      end
      // Inputs are settled here and hold until the next rising edge
      #1;
      if (req_valid_i && req_ready_o) begin
        pend_addr.push_back(req_addr_i);
        pend_due.push_back(cycle + 1 + rand_bits(long_delay_i ? LONG_DELAY_W : SHORT_DELAY_W));
        stall_run = 0;
      end else if (req_valid_i) begin
        stall_run++;
      end
      if (rsp_valid_o && rsp_ready_i) begin
        void'(pend_addr.pop_front());
        void'(pend_due.pop_front());
      end
      ready_next = !(stall_en_i && stall_run < MAX_STALL && rand_bits(1) == 32'd1);
    end
  end

endmodule

// File: verif/tb_icache_bypass.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench top: clock, reset, watchdog, fetch stimulus,
// refill request monitor, compare tasks and the DUT
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_icache_bypass;
  timeunit 1ns;
  timeprecision 100ps;
  import icache_bypass_pkg::*;

  localparam int unsigned CLK_PERIOD    = 20;
  localparam int unsigned RESET_CYCLES  = 8;
  localparam int unsigned STALL_LIMIT   = 3;
  localparam int unsigned SHORT_DELAY_W = 2;
  localparam int unsigned LONG_DELAY_W  = 5;
  localparam int unsigned N_CONC        = 12;
  localparam int unsigned N_STALL       = 12;
  localparam int unsigned N_LONG        = 16;
  localparam int unsigned N_FETCHES =
    LINE_WIDTH / FETCH_DW + 2 * (N_CONC + N_STALL + N_LONG) + 2;
  // Each fetch served alone with the longest stall and the longest response delay
  localparam int unsigned WORST_FETCH = STALL_LIMIT + (1 << LONG_DELAY_W) + 8;
  localparam int unsigned WATCHDOG_NS =
    (RESET_CYCLES + N_FETCHES * WORST_FETCH + 200) * CLK_PERIOD;
  localparam fetch_addr_t LINE_OFS_MASK = fetch_addr_t'((1 << LINE_ALIGN) - 1);

  logic                             clk;
  logic                             arst_n;
  fetch_addr_t [NR_FETCH_PORTS-1:0] inst_addr;
  logic        [NR_FETCH_PORTS-1:0] inst_valid;
  logic        [NR_FETCH_PORTS-1:0] inst_ready;
  fetch_data_t [NR_FETCH_PORTS-1:0] inst_data;
  logic        [NR_FETCH_PORTS-1:0] inst_error;
  fetch_addr_t                      refill_req_addr;
  logic                             refill_req_valid;
  logic                             refill_req_ready;
  line_data_t                       refill_rsp_data;
  logic                             refill_rsp_error;
  logic                             refill_rsp_valid;
  logic                             refill_rsp_ready;
  logic                             stall_en;
  logic                             long_delay;
  int unsigned                      fetches_done;

  icache_bypass_top dut0 (
    .clk_i              ( clk              ),
    .arst_n_i           ( arst_n           ),
    .inst_addr_i        ( inst_addr        ),
    .inst_valid_i       ( inst_valid       ),
    .inst_ready_o       ( inst_ready       ),
    .inst_data_o        ( inst_data        ),
    .inst_error_o       ( inst_error       ),
    .refill_req_addr_o  ( refill_req_addr  ),
    .refill_req_valid_o ( refill_req_valid ),
    .refill_req_ready_i ( refill_req_ready ),
    .refill_rsp_data_i  ( refill_rsp_data  ),
    .refill_rsp_error_i ( refill_rsp_error ),
    .refill_rsp_valid_i ( refill_rsp_valid ),
    .refill_rsp_ready_o ( refill_rsp_ready )
  );

  tb_refill_model #(
    .MAX_STALL     ( STALL_LIMIT   ),
    .SHORT_DELAY_W ( SHORT_DELAY_W ),
    .LONG_DELAY_W  ( LONG_DELAY_W  )
  ) model0 (
    .clk_i        ( clk              ),
    .req_addr_i   ( refill_req_addr  ),
    .req_valid_i  ( refill_req_valid ),
    .req_ready_o  ( refill_req_ready ),
    .rsp_data_o   ( refill_rsp_data  ),
    .rsp_error_o  ( refill_rsp_error ),
    .rsp_valid_o  ( refill_rsp_valid ),
    .rsp_ready_i  ( refill_rsp_ready ),
    .stall_en_i   ( stall_en         ),
    .long_delay_i ( long_delay       )
  );

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_word(input string name, input fetch_data_t got, input fetch_data_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("error at %0t: %s is %b, expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_addr(input string name, input fetch_addr_t got, input fetch_addr_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_idle_outputs();
    for (int p = 0; p < NR_FETCH_PORTS; p++) begin
      check_bit($sformatf("inst_ready_o[%0d]", p), inst_ready[port_idx_t'(p)], 1'b0);
    end
    check_bit("refill_req_valid_o", refill_req_valid, 1'b0);
    check_bit("refill_rsp_ready_o", refill_rsp_ready, 1'b0);
  endtask

  // Word aligned random address, top nibble F only when an error is wanted
  function automatic fetch_addr_t draw_addr(input logic bad);
    fetch_addr_t a;
    a = model0.rand_bits(FETCH_AW);
    a[FETCH_ALIGN-1:0] = '0;
    if (bad) begin
      a[FETCH_AW-1 -: 4] = 4'hF;
    end else if (a[FETCH_AW-1 -: 4] == 4'hF) begin
      a[FETCH_AW-1] = 1'b0;
    end
    return a;
  endfunction

  // One fetch on one port, checked against the line reference at the held address
  task automatic fetch(input port_idx_t port, input fetch_addr_t addr);
    line_data_t  line;
    word_sel_t   sel;
    fetch_data_t exp_word;
    logic        exp_error;
    @(negedge clk);
    inst_addr[port]  = addr;
    inst_valid[port] = 1'b1;
    @(negedge clk);
    while (!inst_ready[port]) begin
      @(negedge clk);
    end
    line      = model0.ref_line(addr & ~LINE_OFS_MASK);
    sel       = addr[LINE_ALIGN-1:FETCH_ALIGN];
    exp_word  = fetch_data_t'(line >> (int'(sel) * FETCH_DW));
    exp_error = (addr[FETCH_AW-1 -: 4] == 4'hF);
    check_word($sformatf("inst_data_o[%0d]", port), inst_data[port], exp_word);
    check_bit($sformatf("inst_error_o[%0d]", port), inst_error[port], exp_error);
    inst_valid[port] = 1'b0;
    @(negedge clk);
    check_bit($sformatf("inst_ready_o[%0d]", port), inst_ready[port], 1'b0);
    fetches_done++;
  endtask

  task automatic run_rounds(input int unsigned n);
    fetch_addr_t a0;
    fetch_addr_t a1;
    for (int unsigned r = 0; r < n; r++) begin
      a0 = draw_addr(1'b0);
      a1 = draw_addr(1'b0);
      fork
        fetch(1'b0, a0);
        fetch(1'b1, a1);
      join
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    stop_with_failure($sformatf("watchdog expired with %0d of %0d fetches done",
                                fetches_done, N_FETCHES));
  end

  // Refill request format, pending match and hold under back-pressure
  initial begin
    logic        hold;
    fetch_addr_t hold_addr;
    fetch_addr_t line_addr;
    logic        found;
    hold      = 1'b0;
    hold_addr = '0;
    forever begin
      @(negedge clk);
      #1;
      if (arst_n) begin
        if (hold) begin
          check_bit("refill_req_valid_o", refill_req_valid, 1'b1);
          check_addr("refill_req_addr_o", refill_req_addr, hold_addr);
        end
        if (refill_req_valid) begin
          check_addr("refill_req_addr_o", refill_req_addr & LINE_OFS_MASK, '0);
          found = 1'b0;
          for (int p = 0; p < NR_FETCH_PORTS; p++) begin
            line_addr = inst_addr[port_idx_t'(p)] & ~LINE_OFS_MASK;
            if (inst_valid[port_idx_t'(p)] && line_addr == refill_req_addr) begin
              found = 1'b1;
            end
          end
          if (!found) begin
            stop_with_failure("refill request address matches no pending fetch");
          end
        end
        hold      = refill_req_valid && !refill_req_ready;
        hold_addr = refill_req_addr;
      end
    end
  end

  initial begin
    fetch_addr_t base;
    arst_n       = 1'b0;
    inst_valid   = '0;
    inst_addr    = '0;
    stall_en     = 1'b0;
    long_delay   = 1'b0;
    fetches_done = 0;
    repeat (RESET_CYCLES) @(negedge clk);
    check_idle_outputs();
    arst_n = 1'b1;
    @(negedge clk);
    check_idle_outputs();

    // Walk every word offset of one line on a single port
    base = draw_addr(1'b0);
    for (int w = 0; w < LINE_WIDTH / FETCH_DW; w++) begin
      base[LINE_ALIGN-1:FETCH_ALIGN] = word_sel_t'(w);
      fetch(1'b0, base);
    end

    run_rounds(N_CONC);
    stall_en = 1'b1;
    run_rounds(N_STALL);
    stall_en = 1'b0;
    fetch(1'b0, draw_addr(1'b1));
    fetch(1'b1, draw_addr(1'b1));
    long_delay = 1'b1;
    stall_en   = 1'b1;
    run_rounds(N_LONG);

    @(negedge clk);
    check_bit("refill_rsp_ready_o", refill_rsp_ready, 1'b0);
    if (fetches_done == N_FETCHES) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      stop_with_failure($sformatf("only %0d of %0d fetches completed", fetches_done, N_FETCHES));
    end
  end

endmodule

// File: filelist.f
verilog/icache_bypass_pkg.sv
verilog/bypass_bus_if.sv
verilog/bypass_port_seq.sv
verilog/bypass_req_arb.sv
verilog/bypass_rsp_router.sv
verilog/icache_bypass_top.sv
verif/tb_refill_model.sv
verif/tb_icache_bypass.sv

// File: Makefile
# Verilator build and run of the uncached fetch path testbench

VERILATOR  ?= verilator
TOP        ?= tb_icache_bypass
RTL_TOP    ?= icache_bypass_top
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
